// ==== flist.f ====
src/video_pkg.sv
src/stream_ifs.sv
src/io_regs.sv
src/burst_fetcher.sv
src/word_queue.sv
src/scanout.sv
src/video_fetch_top.sv
tests/video_fetch_assert.sv
tests/tb_video_fetch.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_video_fetch
FLIST = flist.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tests/tb_video_fetch.sv ====
/* plays the external memory and the display, checking sits in the bound checker
   rst_n is active high, beat data is the low 16 bits of its halfword address */
`timescale 1ns/10ps

module tb_video_fetch;

    localparam int MAX_CYCLES = 3 * video_pkg::FRAME_PIXELS * 8 + 2000;

    logic                  clk_cpu      = 1'b0;
    logic                  rst_n        = 1'b1;
    logic                  mem_ack_i    = 1'b0;
    logic                  mem_rvalid_i = 1'b0;
    video_pkg::pixel_t     mem_rdata_i  = '0;
    logic                  pix_req_i    = 1'b0;
    logic                  io_wr_i      = 1'b0;
    logic                  io_rd_i      = 1'b0;
    video_pkg::io_addr_t   io_addr_i    = '0;
    video_pkg::word_t      io_wdata_i   = '0;
    logic                  mem_req_o;
    video_pkg::half_addr_t mem_addr_o;
    logic                  pix_valid_o;
    video_pkg::pixel_t     pix_data_o;
    logic                  pix_sof_o;
    video_pkg::word_t      io_rdata_o;

    integer                seed = 32'h6e98fa84;
    int                    cycles = 0;
    int                    pix_count = 0;
    int                    pause = 0;
    int                    beats_left = 0;
    int                    ack_wait = 2;
    logic [1:0]            disp_mode = 2'd0;   // 0 idle, 1 always, 2 random
    logic [31:0]           disp_rnd = '0;
    logic [31:0]           mem_rnd;
    video_pkg::half_addr_t beat_addr = '0;

    video_fetch_top uut (.*);

    initial begin
        forever #50 clk_cpu = ~clk_cpu;
    end

    task automatic stop_with_failure(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic write_reg(input video_pkg::io_reg_e addr, input video_pkg::word_t data);
        @(posedge clk_cpu);
        io_wr_i    <= 1'b1;
        io_addr_i  <= addr;
        io_wdata_i <= data;
        @(posedge clk_cpu);
        io_wr_i <= 1'b0;
    endtask

    task automatic read_reg(input video_pkg::io_reg_e addr);
        @(posedge clk_cpu);
        io_rd_i   <= 1'b1;
        io_addr_i <= addr;
        @(posedge clk_cpu);
        io_rd_i <= 1'b0;
    endtask

    task automatic wait_pixels(input int n);
        while (pix_count < n)
            @(posedge clk_cpu);
    endtask

    // memory model acks after 0 to 3 cycles and sends beats with random gaps
    always @(posedge clk_cpu) begin
        mem_rnd = $random(seed);
        mem_ack_i    <= 1'b0;
        mem_rvalid_i <= 1'b0;
        if (beats_left > 0) begin
            if (mem_rnd[1:0] != 2'd0) begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= beat_addr[15:0];
                beat_addr    <= beat_addr + 1'b1;
                beats_left   <= beats_left - 1;
            end
        end else if (mem_req_o && !mem_ack_i) begin
            if (ack_wait == 0) begin
                mem_ack_i  <= 1'b1;
                beat_addr  <= mem_addr_o;
                beats_left <= video_pkg::BURST_HALFWORDS;
                ack_wait   <= int'(mem_rnd[3:2]);
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
        disp_rnd <= $random(seed);   // used by the display at the next edge
    end

    // display side
    always @(posedge clk_cpu) begin
        if (disp_mode == 2'd1) begin
            pix_req_i <= 1'b1;
        end else if (disp_mode == 2'd0) begin
            pix_req_i <= 1'b0;
        end else if (pause != 0) begin
            pix_req_i <= 1'b0;
            pause     <= pause - 1;
        end else begin
            pix_req_i <= disp_rnd[0];
            if (disp_rnd[5:1] == 5'd0)
                pause <= 16 + int'(disp_rnd[10:6]);   // long pause
        end
        if (pix_valid_o)
            pix_count <= pix_count + 1;
    end

    always @(posedge clk_cpu) begin
        cycles <= cycles + 1;
        if (uut.u_check.fail_flag)
            stop_with_failure("an assertion in the checker failed");
        else if (cycles >= MAX_CYCLES)
            stop_with_failure("timeout: the pixel stream did not finish in time");
    end

    initial begin
        repeat (2) @(posedge clk_cpu);
        rst_n <= 1'b0;
        read_reg(video_pkg::IO_STATUS);
        // underrun while nothing is fetched yet
        @(posedge clk_cpu);
        disp_mode <= 2'd1;
        repeat (3) @(posedge clk_cpu);
        disp_mode <= 2'd0;
        repeat (3) @(posedge clk_cpu);
        read_reg(video_pkg::IO_STATUS);
        write_reg(video_pkg::IO_CONTROL, 32'h2);
        read_reg(video_pkg::IO_STATUS);
        write_reg(video_pkg::IO_FB_BASE, 32'h0001_2340);
        read_reg(video_pkg::IO_FB_BASE);
        read_reg(video_pkg::IO_MS_COUNT);
        repeat (3 * video_pkg::CYCLES_PER_MS - 2) @(posedge clk_cpu);
        read_reg(video_pkg::IO_MS_COUNT);
        write_reg(video_pkg::IO_CONTROL, 32'h1);
        disp_mode <= 2'd2;
        wait_pixels(video_pkg::FRAME_PIXELS / 2);
        write_reg(video_pkg::IO_FB_BASE, 32'h000a_5f00);   // takes effect next frame
        read_reg(video_pkg::IO_FB_BASE);
        wait_pixels(video_pkg::FRAME_PIXELS + 40);
        // display stalls so the fetcher runs out of credits
        disp_mode <= 2'd0;
        repeat (200) @(posedge clk_cpu);
        disp_mode <= 2'd2;
        wait_pixels(2 * video_pkg::FRAME_PIXELS + 16);
        read_reg(video_pkg::IO_STATUS);
        repeat (4) @(posedge clk_cpu);
        if (uut.u_check.fail_flag) begin
            stop_with_failure("an assertion in the checker failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== tests/video_fetch_assert.sv ====
/* shadow model of the pixel stream, IO registers and memory bursts
   rst_n is active high, all checks are off while it is high */
`timescale 1ns/10ps

module video_fetch_assert (
    input logic                  clk_cpu,
    input logic                  rst_n,
    input logic                  mem_req_o,
    input video_pkg::half_addr_t mem_addr_o,
    input logic                  mem_ack_i,
    input logic                  mem_rvalid_i,
    input logic                  pix_req_i,
    input logic                  pix_valid_o,
    input video_pkg::pixel_t     pix_data_o,
    input logic                  pix_sof_o,
    input logic                  io_wr_i,
    input logic                  io_rd_i,
    input video_pkg::io_addr_t   io_addr_i,
    input video_pkg::word_t      io_wdata_i,
    input video_pkg::word_t      io_rdata_o
);

    logic                  fail_flag;
    int                    cyc;          // edges since reset
    int                    pix_idx;      // index within the frame
    int                    beats_out;    // beats still owed by memory
    int                    hw_cnt;
    int                    px_cnt;
    int                    bursts;
    video_pkg::pixel_t     frame_px;     // base of the frame on display
    video_pkg::half_addr_t sh_base;
    video_pkg::half_addr_t req_base;     // base as seen when the request went out
    video_pkg::half_addr_t fetch_base;   // base of the newest frame fetched
    video_pkg::half_addr_t last_addr;
    logic                  sh_en;
    logic                  sh_underrun;
    logic                  req_d;

    initial fail_flag = 1'b0;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            cyc         <= 0;
            pix_idx     <= 0;
            beats_out   <= 0;
            hw_cnt      <= 0;
            px_cnt      <= 0;
            bursts      <= 0;
            frame_px    <= '0;
            sh_base     <= '0;
            req_base    <= '0;
            fetch_base  <= '0;
            last_addr   <= '0;
            sh_en       <= 1'b0;
            sh_underrun <= 1'b0;
            req_d       <= 1'b0;
        end else begin
            cyc   <= cyc + 1;
            req_d <= pix_req_i;
            if (io_wr_i && io_addr_i == video_pkg::IO_FB_BASE)
                sh_base <= io_wdata_i[video_pkg::HALF_ADDR_W-1:0];
            if (io_wr_i && io_addr_i == video_pkg::IO_CONTROL) begin
                sh_en <= io_wdata_i[0];
                if (io_wdata_i[1])
                    sh_underrun <= 1'b0;
            end
            if (req_d && !pix_valid_o)
                sh_underrun <= 1'b1;   // request answered with no pixel
            if (!mem_req_o)
                req_base <= sh_base;   // frozen while a request is pending
            if (mem_req_o && mem_ack_i) begin
                beats_out <= video_pkg::BURST_HALFWORDS;
                bursts    <= bursts + 1;
                last_addr <= mem_addr_o;
                if (bursts % video_pkg::BURSTS_PER_FRAME == 0)
                    fetch_base <= req_base;
            end else if (mem_rvalid_i) begin
                beats_out <= beats_out - 1;
            end
            if (mem_rvalid_i)
                hw_cnt <= hw_cnt + 1;
            if (pix_valid_o) begin
                px_cnt  <= px_cnt + 1;
                pix_idx <= pix_idx == video_pkg::FRAME_PIXELS - 1 ? 0 : pix_idx + 1;
                if (pix_idx == 0)
                    frame_px <= fetch_base[15:0];
            end
        end
    end

    a_sof: assert property (@(posedge clk_cpu) disable iff (rst_n)
        pix_valid_o |-> pix_sof_o == (pix_idx == 0))
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: pix_sof_o wrong at pixel index %0d", $time, pix_idx);
        end

    // the queue is far shorter than a frame, so index 0 always belongs to the newest base
    a_order: assert property (@(posedge clk_cpu) disable iff (rst_n)
        pix_valid_o |-> pix_data_o ==
            (pix_idx == 0 ? fetch_base[15:0] : frame_px) + video_pkg::pixel_t'(pix_idx))
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: pixel %0d has data %h", $time, pix_idx, pix_data_o);
        end

    // burst 0 starts at the base written before its request, later bursts follow on
    a_addr: assert property (@(posedge clk_cpu) disable iff (rst_n)
        mem_req_o && mem_ack_i |->
            mem_addr_o == ((bursts % video_pkg::BURSTS_PER_FRAME == 0) ? req_base :
                           last_addr + video_pkg::half_addr_t'(video_pkg::BURST_HALFWORDS)))
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: burst address %h unexpected", $time, mem_addr_o);
        end

    a_req_hold: assert property (@(posedge clk_cpu) disable iff (rst_n)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: mem_req_o dropped or address moved before ack", $time);
        end

    a_one_burst: assert property (@(posedge clk_cpu) disable iff (rst_n)
        $rose(mem_req_o) |-> beats_out == 0)
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: new request with %0d beats outstanding", $time, beats_out);
        end

    // queue occupancy in halfwords
    a_credit: assert property (@(posedge clk_cpu) disable iff (rst_n)
        hw_cnt - px_cnt <= 2 * video_pkg::QUEUE_WORDS)
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: %0d halfwords buffered", $time, hw_cnt - px_cnt);
        end

    a_rd_base: assert property (@(posedge clk_cpu) disable iff (rst_n)
        io_rd_i && io_addr_i == video_pkg::IO_FB_BASE |=>
            io_rdata_o == video_pkg::word_t'($past(sh_base)))
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: frame base read %h", $time, io_rdata_o);
        end

    a_rd_ms: assert property (@(posedge clk_cpu) disable iff (rst_n)
        io_rd_i && io_addr_i == video_pkg::IO_MS_COUNT |=>
            io_rdata_o == video_pkg::word_t'($past(cyc) / video_pkg::CYCLES_PER_MS))
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: millisecond count read %0d", $time, io_rdata_o);
        end

    a_rd_status: assert property (@(posedge clk_cpu) disable iff (rst_n)
        io_rd_i && io_addr_i == video_pkg::IO_STATUS |=>
            io_rdata_o[1:0] == $past({sh_en, sh_underrun}))
        else begin
            fail_flag = 1'b1;
            $error("ERROR %0t: status read %h", $time, io_rdata_o);
        end

endmodule

bind video_fetch_top video_fetch_assert u_check (.*);

// ==== src/video_fetch_top.sv ====
/* single clock domain, reset is synchronous and active high despite its name
   memory side expects one burst of BURST_HALFWORDS beats per ack */
`timescale 1ns/10ps

module video_fetch_top (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    // external memory
    output logic                  mem_req_o,
    output video_pkg::half_addr_t mem_addr_o,
    input  logic                  mem_ack_i,
    input  logic                  mem_rvalid_i,
    input  video_pkg::pixel_t     mem_rdata_i,
    // display
    input  logic                  pix_req_i,
    output logic                  pix_valid_o,
    output video_pkg::pixel_t     pix_data_o,
    output logic                  pix_sof_o,
    // io bus
    input  logic                  io_wr_i,
    input  logic                  io_rd_i,
    input  video_pkg::io_addr_t   io_addr_i,
    input  video_pkg::word_t      io_wdata_i,
    output video_pkg::word_t      io_rdata_o
);

    logic                  fetch_en;
    logic                  underrun;   // one-cycle pulse from scanout
    video_pkg::half_addr_t fb_base;

    fill_if  fill ();
    drain_if drain ();

    io_regs u_io_regs (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .io_wr_i    (io_wr_i),
        .io_rd_i    (io_rd_i),
        .io_addr_i  (io_addr_i),
        .io_wdata_i (io_wdata_i),
        .io_rdata_o (io_rdata_o),
        .underrun_i (underrun),
        .fetch_en_o (fetch_en),
        .fb_base_o  (fb_base)
    );

    burst_fetcher u_fetcher (
        .clk_cpu      (clk_cpu),
        .rst_n        (rst_n),
        .fetch_en_i   (fetch_en),
        .fb_base_i    (fb_base),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .fill         (fill.producer)
    );

    word_queue u_queue (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .fill    (fill.buffer_in),
        .drain   (drain.buffer_out)
    );

    scanout u_scanout (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .pix_req_i   (pix_req_i),
        .drain       (drain.consumer),
        .pix_valid_o (pix_valid_o),
        .pix_data_o  (pix_data_o),
        .pix_sof_o   (pix_sof_o),
        .underrun_o  (underrun)
    );

endmodule

// ==== src/scanout.sv ====
/* pixel comes out one cycle after pix_req_i, low half of each word first
   a request on an empty queue gives no pixel and flags underrun */
`timescale 1ns/10ps

module scanout (
    input  logic              clk_cpu,
    input  logic              rst_n,
    input  logic              pix_req_i,
    drain_if.consumer         drain,
    output logic              pix_valid_o,
    output video_pkg::pixel_t pix_data_o,
    output logic              pix_sof_o,
    output logic              underrun_o
);

    logic high_half;   // next pixel comes from word[31:16]
    logic take;

    assign take      = pix_req_i && !drain.empty;
    assign drain.pop = take && high_half;   // word done after its high half

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            high_half   <= 1'b0;
            pix_valid_o <= 1'b0;
            pix_sof_o   <= 1'b0;
            underrun_o  <= 1'b0;
        end else begin
            pix_valid_o <= take;
            pix_sof_o   <= take && !high_half && drain.sof;
            underrun_o  <= pix_req_i && drain.empty;
            if (take)
                high_half <= !high_half;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (take)
            pix_data_o <= high_half ? drain.word[31:16] : drain.word[15:0];
    end

endmodule

// ==== src/word_queue.sv ====
/* no full flag, the producer's credit count keeps pushes in bounds
   head word and sof are read combinationally */
`timescale 1ns/10ps

module word_queue (
    input  logic        clk_cpu,
    input  logic        rst_n,
    fill_if.buffer_in   fill,
    drain_if.buffer_out drain
);

    video_pkg::word_t              word_mem [video_pkg::QUEUE_WORDS];
    logic                          sof_mem  [video_pkg::QUEUE_WORDS];
    logic [video_pkg::QUEUE_AW:0]  wr_ptr;   // extra bit tells full from empty
    logic [video_pkg::QUEUE_AW:0]  rd_ptr;

    assign drain.empty = wr_ptr == rd_ptr;
    assign drain.word  = word_mem[rd_ptr[video_pkg::QUEUE_AW-1:0]];
    assign drain.sof   = sof_mem[rd_ptr[video_pkg::QUEUE_AW-1:0]];

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill.credit <= 1'b0;
        end else begin
            if (fill.push)
                wr_ptr <= wr_ptr + 1'b1;
            if (drain.pop)
                rd_ptr <= rd_ptr + 1'b1;
            fill.credit <= drain.pop;   // each freed slot goes back as a credit
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (fill.push) begin
            word_mem[wr_ptr[video_pkg::QUEUE_AW-1:0]] <= fill.word;
            sof_mem[wr_ptr[video_pkg::QUEUE_AW-1:0]]  <= fill.sof;
        end
    end

endmodule

// ==== src/burst_fetcher.sv ====
/* one burst outstanding at a time, issued only with a full burst of credits
   frame base is sampled when burst 0 of a frame is issued */
`timescale 1ns/10ps

module burst_fetcher (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  logic                  fetch_en_i,
    input  video_pkg::half_addr_t fb_base_i,
    output logic                  mem_req_o,
    output video_pkg::half_addr_t mem_addr_o,
    input  logic                  mem_ack_i,
    input  logic                  mem_rvalid_i,
    input  video_pkg::pixel_t     mem_rdata_i,
    fill_if.producer              fill
);

    video_pkg::fetch_state_e           state;
    video_pkg::credit_t                credits;
    video_pkg::credit_t                credits_nxt;
    logic [video_pkg::BURST_IDX_W-1:0] burst_idx;
    logic [video_pkg::BEAT_W-1:0]      beat_cnt;
    video_pkg::half_addr_t             frame_base;
    video_pkg::half_addr_t             base_sel;
    video_pkg::pixel_t                 low_half;   // even beat waiting for its partner
    logic                              start;
    logic                              accept;
    logic                              beat;
    logic                              last_beat;

    assign start = state == video_pkg::FETCH_IDLE && fetch_en_i &&
                   32'(credits) >= video_pkg::BURST_WORDS;
    assign accept    = state == video_pkg::FETCH_REQ && mem_ack_i;
    assign beat      = state == video_pkg::FETCH_DATA && mem_rvalid_i;
    assign last_beat = beat && 32'(beat_cnt) == video_pkg::BURST_HALFWORDS - 1;
    assign base_sel  = burst_idx == '0 ? fb_base_i : frame_base;
    assign mem_req_o = state == video_pkg::FETCH_REQ;   // addr is stable while high

    // credits come back one per popped word, leave a whole burst at a time
    always_comb begin
        credits_nxt = credits;
        if (fill.credit)
            credits_nxt = credits_nxt + 1'b1;
        if (accept)
            credits_nxt = credits_nxt - video_pkg::credit_t'(video_pkg::BURST_WORDS);
    end

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            state     <= video_pkg::FETCH_IDLE;
            credits   <= video_pkg::credit_t'(video_pkg::QUEUE_WORDS);
            burst_idx <= '0;
            beat_cnt  <= '0;
            fill.push <= 1'b0;
        end else begin
            credits   <= credits_nxt;
            fill.push <= beat && beat_cnt[0];   // odd beat completes a word
            case (state)
                video_pkg::FETCH_IDLE:
                    if (start)
                        state <= video_pkg::FETCH_REQ;
                video_pkg::FETCH_REQ:
                    if (mem_ack_i) begin
                        state    <= video_pkg::FETCH_DATA;
                        beat_cnt <= '0;
                    end
                video_pkg::FETCH_DATA:
                    if (mem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= video_pkg::FETCH_IDLE;
                            if (32'(burst_idx) == video_pkg::BURSTS_PER_FRAME - 1)
                                burst_idx <= '0;   // frame wrap
                            else
                                burst_idx <= burst_idx + 1'b1;
                        end
                    end
                default: state <= video_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (start) begin
            frame_base <= base_sel;
            mem_addr_o <= base_sel + video_pkg::half_addr_t'(burst_idx) *
                          video_pkg::half_addr_t'(video_pkg::BURST_HALFWORDS);
        end
        if (beat && !beat_cnt[0])
            low_half <= mem_rdata_i;
        if (beat && beat_cnt[0]) begin
            fill.word <= {mem_rdata_i, low_half};   // first beat in the low half
            fill.sof  <= burst_idx == '0 && beat_cnt[video_pkg::BEAT_W-1:1] == '0;
        end
    end

endmodule

// ==== src/io_regs.sv ====
/* writes land one cycle after io_wr_i, read data is registered
   a new frame base is only picked up by the fetcher at the next frame start */
`timescale 1ns/10ps

module io_regs (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  logic                  io_wr_i,
    input  logic                  io_rd_i,
    input  video_pkg::io_addr_t   io_addr_i,
    input  video_pkg::word_t      io_wdata_i,
    output video_pkg::word_t      io_rdata_o,
    input  logic                  underrun_i,
    output logic                  fetch_en_o,
    output video_pkg::half_addr_t fb_base_o
);

    logic [video_pkg::MS_PRE_W-1:0] prescale;
    video_pkg::word_t               ms_count;
    logic                           underrun;   // sticky
    logic                           ms_tick;

    assign ms_tick = 32'(prescale) == video_pkg::CYCLES_PER_MS - 1;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            prescale   <= '0;
            ms_count   <= '0;
            fb_base_o  <= '0;
            fetch_en_o <= 1'b0;
            underrun   <= 1'b0;
        end else begin
            prescale <= ms_tick ? '0 : prescale + 1'b1;
            ms_count <= ms_count + video_pkg::word_t'(ms_tick);
            if (io_wr_i) begin
                case (video_pkg::io_reg_e'(io_addr_i))
                    video_pkg::IO_FB_BASE: fb_base_o <= io_wdata_i[video_pkg::HALF_ADDR_W-1:0];
                    video_pkg::IO_CONTROL: begin
                        fetch_en_o <= io_wdata_i[0];
                        if (io_wdata_i[1])
                            underrun <= 1'b0;
                    end
                    default: ;
                endcase
            end
            if (underrun_i)
                underrun <= 1'b1;   // a new event beats a clear in the same cycle
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (io_rd_i) begin
            case (video_pkg::io_reg_e'(io_addr_i))
                video_pkg::IO_MS_COUNT: io_rdata_o <= ms_count;
                video_pkg::IO_FB_BASE:  io_rdata_o <= video_pkg::word_t'(fb_base_o);
                video_pkg::IO_STATUS:   io_rdata_o <= {30'd0, fetch_en_o, underrun};
                default:                io_rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== src/stream_ifs.sv ====
/* fill side is credit based, push never checks for space
   drain side shows the queue head combinationally */
`timescale 1ns/10ps

interface fill_if;
    logic              push;
    video_pkg::word_t  word;
    logic              sof;      // first word of a frame
    logic              credit;   // one pulse per word popped downstream

    modport producer  (output push, output word, output sof, input credit);
    modport buffer_in (input push, input word, input sof, output credit);
endinterface

interface drain_if;
    logic              pop;
    video_pkg::word_t  word;
    logic              sof;
    logic              empty;

    // pop only while empty is low
    modport buffer_out (input pop, output word, output sof, output empty);
    modport consumer   (output pop, input word, input sof, input empty);
endinterface

// ==== src/video_pkg.sv ====
/* geometry is scaled down for simulation, one burst is 32 bytes (16 halfword beats)
   widths below assume power-of-two burst, frame and queue sizes */
package video_pkg;

    localparam int FRAME_W          = 32;
    localparam int FRAME_H          = 8;
    localparam int FRAME_PIXELS     = FRAME_W * FRAME_H;
    localparam int BURST_HALFWORDS  = 16;                    // beats per burst
    localparam int BURST_WORDS      = BURST_HALFWORDS / 2;   // after pairing
    localparam int BURSTS_PER_FRAME = FRAME_PIXELS / BURST_HALFWORDS;
    localparam int QUEUE_WORDS      = 32;                    // also initial credits
    localparam int CYCLES_PER_MS    = 10;
    localparam int HALF_ADDR_W      = 24;

    localparam int BEAT_W      = $clog2(BURST_HALFWORDS);
    localparam int BURST_IDX_W = $clog2(BURSTS_PER_FRAME);
    localparam int QUEUE_AW    = $clog2(QUEUE_WORDS);
    localparam int CREDIT_W    = $clog2(QUEUE_WORDS + 1);   // must hold QUEUE_WORDS itself
    localparam int MS_PRE_W    = $clog2(CYCLES_PER_MS);

    typedef logic [31:0]            word_t;
    typedef logic [15:0]            pixel_t;    // rgb565, also one memory beat
    typedef logic [HALF_ADDR_W-1:0] half_addr_t;
    typedef logic [4:0]             io_addr_t;
    typedef logic [CREDIT_W-1:0]    credit_t;

    typedef enum logic [4:0] {
        IO_MS_COUNT = 5'd0,   // read only
        IO_FB_BASE  = 5'd1,
        IO_STATUS   = 5'd2,   // bit0 underrun, bit1 fetch enabled
        IO_CONTROL  = 5'd3    // bit0 fetch enable, bit1 clear underrun
    } io_reg_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_DATA
    } fetch_state_e;

endpackage
